// ==== Makefile ====
# Verilator build and run for the multiply/divide unit.

VERILATOR ?= verilator
TOP       ?= tb_mdr
FILELIST  ?= files.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert --timescale 1ns/100ps
LINTFLAGS ?= --lint-only -Wall --timing --assert --timescale 1ns/100ps
SIM_ARGS  ?= +verilator+error+limit+100

FAIL_MSG := Result: FAILED
PASS_MSG := Result: PASSED
SOURCES  := $(shell grep -v '^+' $(FILELIST))

.PHONY: all build run lint clean

all: run

build: $(OBJ_DIR)/V$(TOP)

$(OBJ_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: build
	./$(OBJ_DIR)/V$(TOP) $(SIM_ARGS) 2>&1 | tee $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "simulation failed, see $(LOG)"; exit 1; \
	fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then \
		echo "simulation ended without a pass line, see $(LOG)"; exit 1; \
	fi
	@echo "simulation passed"

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== files.f ====
hdl/pkg_system_mdr.sv
hdl/pkg_ctrl_mdr.sv
hdl/mdr_control.sv
hdl/mdr_alu.sv
hdl/division.sv
hdl/multiplication.sv
hdl/mdr_top.sv
verif/mdr_chk.sv
verif/tb_mdr.sv

// ==== hdl/division.sv ====
`timescale 1ns/100ps
`default_nettype none

module division
	import pkg_system_mdr::*;
	import pkg_ctrl_mdr::*;
(
	input  wire logic      clk,
	input  wire logic      i_rst_n,
	input  wire mdr_ctrl_t i_ctrl,
	input  wire data_in_t  i_dividend,
	input  wire data_in_t  i_divisor,
	input  wire alu_res_t  i_alu,

	output alu_req_t       o_alu_req,
	output div_res_t       o_result
);

	data_in_t rem_q;	// partial remainder.
	data_in_t dvd_q;	// dividend bits still to bring in.
	data_in_t divisor_q;
	data_in_t quo_q;
	data_t    rem_shift;
	logic     borrow;
	logic     active;

	assign active = (i_ctrl.op == OP_DIV);

	// ****************************************
	// trial subtraction
	// ****************************************
	assign rem_shift = {rem_q, dvd_q[DW-1]};	// next dividend bit in.

	always_comb begin
		o_alu_req.a = rem_shift;
		o_alu_req.b = {1'b0, divisor_q};
	end

	assign borrow = i_alu.res[DW2-1];

	// ****************************************
	// working registers
	// ****************************************
	always_ff @(posedge clk) begin
		if (i_ctrl.load) begin
			rem_q     <= '0;
			dvd_q     <= i_dividend;
			divisor_q <= i_divisor;
			quo_q     <= '0;
		end else if (i_ctrl.step && active) begin
			if (!borrow)
				rem_q <= i_alu.res[DW-1:0];	// keep difference.
			else
				rem_q <= rem_shift[DW-1:0];	// restore.
			dvd_q <= {dvd_q[DW-2:0], 1'b0};
			quo_q <= {quo_q[DW-2:0], ~borrow};
		end
	end

	// final registers, stable until the next division ends.
	always_ff @(posedge clk) begin
		if (!i_rst_n) begin
			o_result <= '0;
		end else if (i_ctrl.done && active) begin
			o_result.remainder <= rem_q;
			o_result.quotient  <= quo_q;
		end
	end

endmodule

`default_nettype wire

// ==== hdl/mdr_alu.sv ====
`timescale 1ns/100ps
`default_nettype none

module mdr_alu
	import pkg_system_mdr::*;
	import pkg_ctrl_mdr::*;
(
	input  wire op_t      i_op,
	input  wire alu_req_t i_div_req,
	input  wire alu_req_t i_mul_req,

	output alu_res_t      o_res
);

	alu_req_t sel;

	// only the datapath of the running op is served.
	assign sel = (i_op == OP_DIV) ? i_div_req : i_mul_req;

	always_comb begin
		if (i_op == OP_DIV)
			o_res.res = sel.a - sel.b;	// msb set means borrow.
		else
			o_res.res = sel.a + sel.b;	// msb is carry out.
	end

endmodule

`default_nettype wire

// ==== hdl/mdr_control.sv ====
`timescale 1ns/100ps
`default_nettype none

module mdr_control
	import pkg_system_mdr::*;
	import pkg_ctrl_mdr::*;
(
	input  wire logic clk,
	input  wire logic i_rst_n,
	input  wire logic i_req,
	input  wire op_t  i_op,

	output logic      o_ack,
	output mdr_ctrl_t o_ctrl
);

	state_t   state_q;
	state_t   state_d;
	counter_t cnt_q;
	op_t      op_q;
	logic     last_step;

	assign last_step = (cnt_q == counter_t'(DW - 1));

	// ****************************************
	// next state
	// ****************************************
	always_comb begin
		state_d = state_q;
		case (state_q)
			IDLE: begin
				if (i_req)
					state_d = RUN;
			end
			RUN: begin
				if (last_step)
					state_d = DONE;
			end
			DONE: state_d = HOLD;
			HOLD: begin
				// wait for the master to drop req.
				if (!i_req)
					state_d = IDLE;
			end
			default: state_d = IDLE;
		endcase
	end

	always_ff @(posedge clk) begin
		if (!i_rst_n) begin
			state_q <= IDLE;
			cnt_q   <= '0;
			op_q    <= OP_MUL;
		end else begin
			state_q <= state_d;
			if (state_q == IDLE) begin
				cnt_q <= '0;
				if (i_req)
					op_q <= i_op;	// op fixed for the whole run.
			end else if (state_q == RUN) begin
				cnt_q <= cnt_q + counter_t'(1);
			end
		end
	end

	// ****************************************
	// outputs
	// ****************************************
	always_comb begin
		o_ctrl.load = (state_q == IDLE) && i_req;	// load on the req sample.
		o_ctrl.step = (state_q == RUN);
		o_ctrl.done = (state_q == DONE);
		o_ctrl.op   = op_q;
	end

	assign o_ack = (state_q == HOLD);

endmodule

`default_nettype wire

// ==== hdl/mdr_top.sv ====
`timescale 1ns/100ps
`default_nettype none

module mdr_top
	import pkg_system_mdr::*;
	import pkg_ctrl_mdr::*;
(
	input  wire logic     clk,
	input  wire logic     i_rst_n,
	input  wire logic     i_req,
	input  wire op_t      i_op,
	input  wire data_in_t i_a,
	input  wire data_in_t i_b,

	output logic          o_ack,
	output mdr_result_u   o_result
);

	mdr_ctrl_t       ctrl;
	alu_req_t        div_req;
	alu_req_t        mul_req;
	alu_res_t        alu_res;
	div_res_t        div_res;
	logic [2*DW-1:0] mul_product;
	mdr_result_u     div_view;
	mdr_result_u     mul_view;

	mdr_control u_control (
		.clk     (clk),
		.i_rst_n (i_rst_n),
		.i_req   (i_req),
		.i_op    (i_op),
		.o_ack   (o_ack),
		.o_ctrl  (ctrl)
	);

	mdr_alu u_alu (
		.i_op      (ctrl.op),
		.i_div_req (div_req),
		.i_mul_req (mul_req),
		.o_res     (alu_res)
	);

	division u_division (
		.clk        (clk),
		.i_rst_n    (i_rst_n),
		.i_ctrl     (ctrl),
		.i_dividend (i_a),
		.i_divisor  (i_b),
		.i_alu      (alu_res),
		.o_alu_req  (div_req),
		.o_result   (div_res)
	);

	multiplication u_multiplication (
		.clk            (clk),
		.i_rst_n        (i_rst_n),
		.i_ctrl         (ctrl),
		.i_multiplicand (i_a),
		.i_multiplier   (i_b),
		.i_alu          (alu_res),
		.o_alu_req      (mul_req),
		.o_product      (mul_product)
	);

	// ****************************************
	// result word
	// ****************************************
	assign div_view.divres  = div_res;
	assign mul_view.product = mul_product;
	assign o_result = (ctrl.op == OP_DIV) ? div_view : mul_view;	// latched op.

endmodule

`default_nettype wire

// ==== hdl/multiplication.sv ====
`timescale 1ns/100ps
`default_nettype none

module multiplication
	import pkg_system_mdr::*;
	import pkg_ctrl_mdr::*;
(
	input  wire logic      clk,
	input  wire logic      i_rst_n,
	input  wire mdr_ctrl_t i_ctrl,
	input  wire data_in_t  i_multiplicand,
	input  wire data_in_t  i_multiplier,
	input  wire alu_res_t  i_alu,

	output alu_req_t        o_alu_req,
	output logic [2*DW-1:0] o_product
);

	data_in_t        mcand_q;
	logic [2*DW-1:0] prod_q;	// upper half product, lower half multiplier.
	data_in_t        prod_hi;
	logic            active;

	assign active  = (i_ctrl.op == OP_MUL);
	assign prod_hi = prod_q[2*DW-1:DW];

	always_comb begin
		o_alu_req.a = {1'b0, prod_hi};
		o_alu_req.b = {1'b0, mcand_q};
	end

	// ****************************************
	// shift and add
	// ****************************************
	always_ff @(posedge clk) begin
		if (i_ctrl.load) begin
			mcand_q <= i_multiplicand;
			prod_q  <= {{DW{1'b0}}, i_multiplier};
		end else if (i_ctrl.step && active) begin
			if (prod_q[0])
				prod_q <= {i_alu.res, prod_q[DW-1:1]};	// carry shifts in.
			else
				prod_q <= {1'b0, prod_hi, prod_q[DW-1:1]};
		end
	end

	always_ff @(posedge clk) begin
		if (!i_rst_n)
			o_product <= '0;
		else if (i_ctrl.done && active)
			o_product <= prod_q;
	end

endmodule

`default_nettype wire

// ==== hdl/pkg_ctrl_mdr.sv ====
`default_nettype none

package pkg_ctrl_mdr;

	localparam int CNT_W = 4;	// enough for DW steps.

	typedef enum logic {
		OP_MUL = 1'b0,
		OP_DIV = 1'b1
	} op_t;

	// ****************************************
	// sequencer
	// ****************************************
	typedef enum logic [1:0] {
		IDLE = 2'd0,
		RUN  = 2'd1,
		DONE = 2'd2,
		HOLD = 2'd3
	} state_t;

	typedef logic [CNT_W-1:0] counter_t;

	// control word shared by both datapaths and the alu.
	typedef struct packed {
		logic load;	// capture operands.
		logic step;	// one iteration.
		logic done;	// latch final result.
		op_t  op;	// op latched at load.
	} mdr_ctrl_t;

endpackage

`default_nettype wire

// ==== hdl/pkg_system_mdr.sv ====
`default_nettype none

package pkg_system_mdr;

	// ****************************************
	// widths
	// ****************************************
	localparam int DW  = 8;		// operand width.
	localparam int DW2 = DW + 1;	// alu word, keeps borrow/carry.

	typedef logic [DW-1:0]  data_in_t;
	typedef logic [DW2-1:0] data_t;

	// one alu request per datapath.
	typedef struct packed {
		data_t a;
		data_t b;
	} alu_req_t;

	// msb of res is borrow on sub, carry on add.
	typedef struct packed {
		data_t res;
	} alu_res_t;

	typedef struct packed {
		data_in_t remainder;
		data_in_t quotient;
	} div_res_t;

	// ****************************************
	// result word, decoded by op
	// ****************************************
	typedef union packed {
		logic [2*DW-1:0] product;
		div_res_t        divres;
	} mdr_result_u;

endpackage

`default_nettype wire

// ==== verif/mdr_chk.sv ====
`timescale 1ns/100ps
`default_nettype none

module mdr_chk
	import pkg_system_mdr::*;
	import pkg_ctrl_mdr::*;
(
	input wire logic        clk,
	input wire logic        i_rst_n,
	input wire logic        i_req,
	input wire logic        i_ack,
	input wire mdr_ctrl_t   i_ctrl,
	input wire mdr_result_u i_result
);

	int unsigned n_ack_rise    = 0;
	int unsigned n_ack_fall    = 0;
	int unsigned n_result_hold = 0;
	int unsigned n_latency     = 0;

	// ****************************************
	// four-phase handshake
	// ****************************************
	a_ack_rise: assert property (@(posedge clk) disable iff (!i_rst_n)
		(!i_ack && !i_req) |=> !i_ack)
	else begin
		n_ack_rise++;
		$error("o_ack rose while i_req was low");
	end

	a_ack_fall: assert property (@(posedge clk) disable iff (!i_rst_n)
		(i_ack && i_req) |=> i_ack)
	else begin
		n_ack_fall++;
		$error("o_ack fell while i_req was high");
	end

	a_result_hold: assert property (@(posedge clk) disable iff (!i_rst_n)
		(i_ack && $past(i_ack)) |-> $stable(i_result))
	else begin
		n_result_hold++;
		$error("o_result changed while o_ack was high");
	end

	// load seen at edge k, ack first sampled high at edge k+DW+2.
	a_latency: assert property (@(posedge clk) disable iff (!i_rst_n)
		$rose(i_ack) == $past(i_ctrl.load, DW + 2))
	else begin
		n_latency++;
		$error("o_ack did not rise DW+1 cycles after the request");
	end

endmodule

bind mdr_top mdr_chk u_mdr_chk (
	.clk      (clk),
	.i_rst_n  (i_rst_n),
	.i_req    (i_req),
	.i_ack    (o_ack),
	.i_ctrl   (ctrl),
	.i_result (o_result)
);

`default_nettype wire

// ==== verif/tb_mdr.sv ====
`timescale 1ns/100ps
`default_nettype none

module tb_mdr
	import pkg_system_mdr::*;
	import pkg_ctrl_mdr::*;
();

	localparam int          CLK_HALF = 4;
	localparam logic [31:0] SEED     = 32'hc24d325d;
	localparam int          ACK_WAIT = 4 * DW;	// cycles before a missing ack counts.
	localparam int          N_RANDOM = 200;
	// about 230 ops of some 13 cycles each, plus margin.
	localparam int          TIMEOUT_CYCLES = 5000;

	typedef logic [2*DW-1:0] word_t;

	logic        clk;
	logic        rst_n;
	logic        req;
	op_t         op;
	data_in_t    a;
	data_in_t    b;
	logic        ack;
	mdr_result_u result;

	int          errors = 0;
	int          checks = 0;
	int unsigned asrt_fails;
	int unsigned cycle_cnt = 0;
	logic [31:0] rnd;

	mdr_top dut (
		.clk      (clk),
		.i_rst_n  (rst_n),
		.i_req    (req),
		.i_op     (op),
		.i_a      (a),
		.i_b      (b),
		.o_ack    (ack),
		.o_result (result)
	);

	initial begin
		clk = 1'b0;
		forever #CLK_HALF clk = ~clk;
	end

	always @(posedge clk) begin
		cycle_cnt <= cycle_cnt + 1;
		if (cycle_cnt == TIMEOUT_CYCLES) begin
			$display("run stopped after %0d cycles, the tests did not finish", cycle_cnt);
			$display("Result: FAILED");
			$finish;
		end
	end

	task automatic check_value(input string name, input word_t expected, input word_t actual);
		checks++;
		if (actual !== expected) begin
			errors++;
			$display("[FAIL] t=%0t %s expected %0d got %0d", $time, name, expected, actual);
		end
	endtask

	// ****************************************
	// one four-phase transaction
	// ****************************************
	task automatic do_op(input op_t t_op, input data_in_t t_a, input data_in_t t_b,
			input int hold);
		mdr_result_u got;
		mdr_result_u exp_res;
		data_in_t    exp_quo;
		data_in_t    exp_rem;
		word_t       exp_prod;
		int          lat;
		int          wait_cnt;

		// divide by zero gives all ones and the dividend back.
		exp_quo  = (t_b == '0) ? {DW{1'b1}} : t_a / t_b;
		exp_rem  = (t_b == '0) ? t_a : t_a % t_b;
		exp_prod = {{DW{1'b0}}, t_a} * {{DW{1'b0}}, t_b};
		if (t_op == OP_DIV) begin
			exp_res.divres.remainder = exp_rem;
			exp_res.divres.quotient  = exp_quo;
		end else begin
			exp_res.product = exp_prod;
		end

		@(posedge clk);
		req <= 1'b1;
		op  <= t_op;
		a   <= t_a;
		b   <= t_b;
		@(posedge clk);	// req sampled in idle.
		lat = 0;
		@(negedge clk);
		while (!ack && lat < ACK_WAIT) begin
			@(negedge clk);
			lat++;
		end
		if (!ack) begin
			errors++;
			$display("no ack within %0d cycles for %s a=%0d b=%0d",
				ACK_WAIT, t_op.name(), t_a, t_b);
		end else begin
			check_value("ack latency", word_t'(DW + 1), word_t'(lat));
			got = result;
			if (t_op == OP_DIV) begin
				check_value("o_result.divres.quotient", word_t'(exp_quo),
					word_t'(got.divres.quotient));
				check_value("o_result.divres.remainder", word_t'(exp_rem),
					word_t'(got.divres.remainder));
			end else begin
				check_value("o_result.product", exp_prod, got.product);
			end
			// master keeps req high, so the unit holds.
			repeat (hold) begin
				@(negedge clk);
				if (!ack) begin
					errors++;
					$display("ack dropped at %0t while req was still high", $time);
				end
				check_value("o_result held", exp_res.product, result.product);
			end
		end
		@(posedge clk);
		req <= 1'b0;
		wait_cnt = 0;
		@(negedge clk);
		while (ack && wait_cnt < ACK_WAIT) begin
			@(negedge clk);
			wait_cnt++;
		end
		if (ack) begin
			errors++;
			$display("ack still high %0d cycles after req was dropped", wait_cnt);
		end
	endtask

	// ****************************************
	// directed tests
	// ****************************************
	task automatic test_reset();
		@(negedge clk);
		check_value("o_ack", word_t'(1'b0), word_t'(ack));
		check_value("o_result", '0, result.product);
	endtask

	task automatic test_div();
		do_op(OP_DIV, 8'd200, 8'd7, 0);
		do_op(OP_DIV, 8'd255, 8'd1, 0);
		do_op(OP_DIV, 8'd5, 8'd9, 0);
		do_op(OP_DIV, 8'd0, 8'd3, 0);
		do_op(OP_DIV, 8'd255, 8'd16, 0);
		do_op(OP_DIV, 8'd100, 8'd10, 0);
	endtask

	task automatic test_mul();
		do_op(OP_MUL, 8'd255, 8'd255, 0);
		do_op(OP_MUL, 8'd0, 8'd77, 0);
		do_op(OP_MUL, 8'd13, 8'd11, 0);
		do_op(OP_MUL, 8'd1, 8'd200, 0);
		do_op(OP_MUL, 8'd128, 8'd2, 0);
	endtask

	task automatic test_div_zero();
		do_op(OP_DIV, 8'd173, 8'd0, 0);
		do_op(OP_DIV, 8'd0, 8'd0, 0);
		do_op(OP_DIV, 8'd255, 8'd0, 0);
	endtask

	task automatic test_backpressure();
		do_op(OP_DIV, 8'd200, 8'd7, 20);
		do_op(OP_MUL, 8'd13, 8'd11, 0);	// other op right after release.
		do_op(OP_MUL, 8'd99, 8'd3, 20);
		do_op(OP_DIV, 8'd99, 8'd3, 0);
	endtask

	task automatic test_random();
		op_t t_op;

		repeat (N_RANDOM) begin
			rnd  = $urandom;
			t_op = rnd[0] ? OP_DIV : OP_MUL;
			do_op(t_op, data_in_t'(rnd[15:8]), data_in_t'(rnd[23:16]), 0);
		end
	endtask

	initial begin
		rst_n = 1'b0;
		req   = 1'b0;
		op    = OP_MUL;
		a     = '0;
		b     = '0;
		rnd   = $urandom(SEED);	// seeds the generator once.
		repeat (2) @(posedge clk);
		rst_n <= 1'b1;

		test_reset();
		test_div();
		test_mul();
		test_div_zero();
		test_backpressure();
		test_random();

		asrt_fails = dut.u_mdr_chk.n_ack_rise + dut.u_mdr_chk.n_ack_fall
			+ dut.u_mdr_chk.n_result_hold + dut.u_mdr_chk.n_latency;
		$display("checks %0d, errors %0d, assertion failures %0d",
			checks, errors, asrt_fails);
		if (errors == 0 && asrt_fails == 0)
			$display("Result: PASSED");
		else
			$display("Result: FAILED");
		$finish;
	end

endmodule

`default_nettype wire
